/* source/isa_pkg.sv */
////////////////////
// encodings of the supported rv32i integer subset
// field positions, opcode and funct codes, and the alu operation set
// decode and the alu refer to these by scoped name
////////////////////
`default_nettype none

package isa_pkg;

	// bit positions of the instruction fields
	localparam int OPCODE_LSB = 0;
	localparam int RD_LSB     = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB    = 15;
	localparam int RS2_LSB    = 20;
	localparam int IMM_LSB    = 20;
	localparam int FUNCT7_LSB = 25;

	// major opcodes
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

	// funct3, shared by register and immediate forms
	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_SLT     = 3'b010;
	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;

	// funct7 of sub, every other op has zero
	localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

endpackage

`default_nettype wire

/* source/core_pkg.sv */
////////////////////
// vector types shared across the out-of-order core
// register values, register numbers and instruction words
// plus the default depth of the reorder buffer
////////////////////
`default_nettype none

package core_pkg;

	// one architectural register value
	typedef logic [31:0] data_t;

	// architectural register number, x0 to x31
	typedef logic [4:0] reg_idx_t;

	// raw instruction word as it arrives from the sender
	typedef logic [31:0] inst_t;

	// in-flight limit, also the credit count after reset
	localparam int DEFAULT_ROB_DEPTH = 8;

endpackage

`default_nettype wire

/* source/instr_decode.sv */
////////////////////
// decode and rename stage
// registers each accepted word, decodes it in the next cycle, renames
// its destination through the map table and resolves both operands
// also holds the architectural register file, written at commit
////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_decode #(
	parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         inst_valid,
	input  core_pkg::inst_t              inst,
	input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
	input  logic                         read_done_a,
	input  logic                         read_done_b,
	input  core_pkg::data_t              read_value_a,
	input  core_pkg::data_t              read_value_b,
	input  logic                         cdb_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag,
	input  core_pkg::data_t              cdb_value,
	input  logic                         commit_valid,
	input  core_pkg::reg_idx_t           commit_reg,
	input  core_pkg::data_t              commit_value,
	input  logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
	output logic                         alloc_valid,
	output core_pkg::reg_idx_t           dest_reg,
	output isa_pkg::alu_op_t             alu_op,
	output logic [$clog2(ROB_DEPTH)-1:0] read_tag_a,
	output logic [$clog2(ROB_DEPTH)-1:0] read_tag_b,
	output core_pkg::data_t              src_value_a,
	output core_pkg::data_t              src_value_b,
	output logic                         src_ready_a,
	output logic                         src_ready_b,
	output logic [$clog2(ROB_DEPTH)-1:0] src_tag_a,
	output logic [$clog2(ROB_DEPTH)-1:0] src_tag_b
);

	localparam int TAG_W = $clog2(ROB_DEPTH);

	// accepted word, allocated one cycle later
	logic            pend_valid;
	core_pkg::inst_t pend_inst;

	// map table, x0 is never mapped
	logic [31:0]      map_valid;
	logic [TAG_W-1:0] map_tag [32];
	core_pkg::data_t  arch_reg [32];

	// raw fields
	logic [6:0]         opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	core_pkg::reg_idx_t rs1;
	core_pkg::reg_idx_t rs2;
	core_pkg::data_t    imm;

	logic supported;
	logic use_imm;

	assign opcode = pend_inst[isa_pkg::OPCODE_LSB +: 7];
	assign funct3 = pend_inst[isa_pkg::FUNCT3_LSB +: 3];
	assign funct7 = pend_inst[isa_pkg::FUNCT7_LSB +: 7];

	////////////////////
	// decode
	////////////////////

	always_comb begin
		alu_op = isa_pkg::ALU_ADD;
		supported = 1'b0;
		use_imm = 1'b0;
		case (opcode)
			isa_pkg::OPCODE_OP: begin
				// only sub may carry a nonzero funct7
				supported = (funct7 == '0) ||
					(funct7 == isa_pkg::FUNCT7_SUB && funct3 == isa_pkg::FUNCT3_ADD_SUB);
				case (funct3)
					isa_pkg::FUNCT3_ADD_SUB: begin
						if (funct7 == isa_pkg::FUNCT7_SUB) begin
							alu_op = isa_pkg::ALU_SUB;
						end
					end
					isa_pkg::FUNCT3_SLT: alu_op = isa_pkg::ALU_SLT;
					isa_pkg::FUNCT3_XOR: alu_op = isa_pkg::ALU_XOR;
					isa_pkg::FUNCT3_OR:  alu_op = isa_pkg::ALU_OR;
					isa_pkg::FUNCT3_AND: alu_op = isa_pkg::ALU_AND;
					default:             supported = 1'b0;
				endcase
			end
			isa_pkg::OPCODE_OP_IMM: begin
				supported = 1'b1;
				use_imm = 1'b1;
				case (funct3)
					isa_pkg::FUNCT3_ADD_SUB: alu_op = isa_pkg::ALU_ADD;
					isa_pkg::FUNCT3_XOR:     alu_op = isa_pkg::ALU_XOR;
					isa_pkg::FUNCT3_OR:      alu_op = isa_pkg::ALU_OR;
					isa_pkg::FUNCT3_AND:     alu_op = isa_pkg::ALU_AND;
					default:                 supported = 1'b0;
				endcase
			end
			default: supported = 1'b0;
		endcase
		// anything else becomes addi x0, x0, 0
		if (!supported) begin
			alu_op = isa_pkg::ALU_ADD;
			use_imm = 1'b1;
		end
	end

	assign rs1 = supported ? pend_inst[isa_pkg::RS1_LSB +: 5] : '0;
	assign rs2 = (supported && !use_imm) ? pend_inst[isa_pkg::RS2_LSB +: 5] : '0;
	assign imm = supported ? {{20{pend_inst[31]}}, pend_inst[isa_pkg::IMM_LSB +: 12]} : '0;
	assign dest_reg = supported ? pend_inst[isa_pkg::RD_LSB +: 5] : '0;
	assign alloc_valid = pend_valid;

	////////////////////
	// operand lookup
	////////////////////

	assign read_tag_a = map_tag[rs1];
	assign read_tag_b = map_tag[rs2];
	assign src_tag_a = map_tag[rs1];
	assign src_tag_b = map_tag[rs2];

	// register file, then finished rob entry, then a result on the bus
	always_comb begin
		src_ready_a = 1'b1;
		src_value_a = arch_reg[rs1];
		if (map_valid[rs1]) begin
			src_ready_a = read_done_a || (cdb_valid && cdb_tag == read_tag_a);
			src_value_a = read_done_a ? read_value_a : cdb_value;
		end
		src_ready_b = 1'b1;
		src_value_b = arch_reg[rs2];
		if (use_imm) begin
			src_value_b = imm;
		end else if (map_valid[rs2]) begin
			src_ready_b = read_done_b || (cdb_valid && cdb_tag == read_tag_b);
			src_value_b = read_done_b ? read_value_b : cdb_value;
		end
	end

	////////////////////
	// state update
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pend_valid <= 1'b0;
			map_valid <= '0;
			for (int i = 0; i < 32; i++) begin
				arch_reg[i] <= '0;
			end
		end else begin
			pend_valid <= inst_valid;
			if (commit_valid && commit_reg != '0) begin
				arch_reg[commit_reg] <= commit_value;
			end
			// free only if no younger producer took the register
			if (commit_valid && map_valid[commit_reg] && map_tag[commit_reg] == commit_tag) begin
				map_valid[commit_reg] <= 1'b0;
			end
			// a rename in the same cycle wins over the free above
			if (alloc_valid && dest_reg != '0) begin
				map_valid[dest_reg] <= 1'b1;
				map_tag[dest_reg] <= alloc_tag;
			end
		end
		pend_inst <= inst;
	end

endmodule

`default_nettype wire

/* source/reservation_station.sv */
////////////////////
// single reservation station in front of the alu
// one slot per rob tag, so slot index and tag are the same
// operands wake from the data bus, the oldest ready slot issues
////////////////////
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
	parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         alloc_valid,
	input  isa_pkg::alu_op_t             alu_op,
	input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
	input  core_pkg::data_t              src_value_a,
	input  core_pkg::data_t              src_value_b,
	input  logic                         src_ready_a,
	input  logic                         src_ready_b,
	input  logic [$clog2(ROB_DEPTH)-1:0] src_tag_a,
	input  logic [$clog2(ROB_DEPTH)-1:0] src_tag_b,
	input  logic                         cdb_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag,
	input  core_pkg::data_t              cdb_value,
	output logic                         issue_valid,
	output isa_pkg::alu_op_t             issue_op,
	output core_pkg::data_t              issue_a,
	output core_pkg::data_t              issue_b,
	output logic [$clog2(ROB_DEPTH)-1:0] issue_tag
);

	localparam int TAG_W = $clog2(ROB_DEPTH);

	logic [ROB_DEPTH-1:0] busy;
	logic [ROB_DEPTH-1:0] ready_a;
	logic [ROB_DEPTH-1:0] ready_b;
	isa_pkg::alu_op_t     op_mem [ROB_DEPTH];
	core_pkg::data_t      value_a [ROB_DEPTH];
	core_pkg::data_t      value_b [ROB_DEPTH];
	logic [TAG_W-1:0]     tag_a [ROB_DEPTH];
	logic [TAG_W-1:0]     tag_b [ROB_DEPTH];

	// issue select
	logic             found;
	logic [TAG_W-1:0] pick;
	logic [TAG_W-1:0] pick_age;

	////////////////////
	// oldest-first select
	////////////////////

	// tags are handed out in order, so the distance from the tail ranks age
	// smaller distance means allocated longer ago
	always_comb begin
		logic [TAG_W-1:0] age;
		found = 1'b0;
		pick = '0;
		pick_age = '1;
		for (int i = 0; i < ROB_DEPTH; i++) begin
			age = TAG_W'(i) - alloc_tag;
			if (busy[i] && ready_a[i] && ready_b[i] && (!found || age < pick_age)) begin
				found = 1'b1;
				pick = TAG_W'(i);
				pick_age = age;
			end
		end
	end

	assign issue_valid = found;
	assign issue_tag = pick;
	assign issue_op = op_mem[pick];
	assign issue_a = value_a[pick];
	assign issue_b = value_b[pick];

	////////////////////
	// slot update
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (found) begin
				busy[pick] <= 1'b0;
			end
			if (alloc_valid) begin
				busy[alloc_tag] <= 1'b1;
			end
		end
		// wakeup of waiting operands
		for (int i = 0; i < ROB_DEPTH; i++) begin
			if (cdb_valid && !ready_a[i] && tag_a[i] == cdb_tag) begin
				ready_a[i] <= 1'b1;
				value_a[i] <= cdb_value;
			end
			if (cdb_valid && !ready_b[i] && tag_b[i] == cdb_tag) begin
				ready_b[i] <= 1'b1;
				value_b[i] <= cdb_value;
			end
		end
		// same-cycle bus results arrive through decode bypass
		if (alloc_valid) begin
			op_mem[alloc_tag] <= alu_op;
			value_a[alloc_tag] <= src_value_a;
			value_b[alloc_tag] <= src_value_b;
			ready_a[alloc_tag] <= src_ready_a;
			ready_b[alloc_tag] <= src_ready_b;
			tag_a[alloc_tag] <= src_tag_a;
			tag_b[alloc_tag] <= src_tag_b;
		end
	end

	// credit flow at the core input keeps one slot free for every allocation
	station_no_overflow: assert property (@(posedge clock) disable iff (reset)
		alloc_valid |-> !(&busy));

endmodule

`default_nettype wire

/* source/alu_unit.sv */
////////////////////
// integer alu, one operation per cycle, never stalls
// the registered result is the broadcast on the data bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
	parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         issue_valid,
	input  isa_pkg::alu_op_t             issue_op,
	input  core_pkg::data_t              issue_a,
	input  core_pkg::data_t              issue_b,
	input  logic [$clog2(ROB_DEPTH)-1:0] issue_tag,
	output logic                         cdb_valid,
	output logic [$clog2(ROB_DEPTH)-1:0] cdb_tag,
	output core_pkg::data_t              cdb_value
);

	core_pkg::data_t result;
	logic            less;

	// signed compare for slt
	assign less = $signed(issue_a) < $signed(issue_b);

	always_comb begin
		case (issue_op)
			isa_pkg::ALU_ADD: result = issue_a + issue_b;
			isa_pkg::ALU_SUB: result = issue_a - issue_b;
			isa_pkg::ALU_AND: result = issue_a & issue_b;
			isa_pkg::ALU_OR:  result = issue_a | issue_b;
			isa_pkg::ALU_XOR: result = issue_a ^ issue_b;
			isa_pkg::ALU_SLT: result = {{31{1'b0}}, less};
			default:          result = '0;
		endcase
	end

	// bus stage
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= issue_valid;
		end
		cdb_tag <= issue_tag;
		cdb_value <= result;
	end

endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
////////////////////
// reorder buffer as a circular queue of in-flight instructions
// the tail is the rename tag of the next allocation
// entries finish from the data bus and retire in order from the head
////////////////////
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
	parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         alloc_valid,
	input  core_pkg::reg_idx_t           dest_reg,
	input  logic [$clog2(ROB_DEPTH)-1:0] read_tag_a,
	input  logic [$clog2(ROB_DEPTH)-1:0] read_tag_b,
	input  logic                         cdb_valid,
	input  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag,
	input  core_pkg::data_t              cdb_value,
	output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
	output logic                         read_done_a,
	output logic                         read_done_b,
	output core_pkg::data_t              read_value_a,
	output core_pkg::data_t              read_value_b,
	output logic                         commit_valid,
	output core_pkg::reg_idx_t           commit_reg,
	output core_pkg::data_t              commit_value,
	output logic [$clog2(ROB_DEPTH)-1:0] commit_tag
);

	localparam int TAG_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = TAG_W + 1;

	// queue pointers
	// depth is a power of two so they wrap freely
	logic [TAG_W-1:0] head;
	logic [TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;

	logic [ROB_DEPTH-1:0] done;
	core_pkg::reg_idx_t   dest_mem [ROB_DEPTH];
	core_pkg::data_t      value_mem [ROB_DEPTH];

	logic             retire;
	logic [TAG_W-1:0] cdb_offset;

	assign alloc_tag = tail;
	assign retire = (count != '0) && done[head];
	assign cdb_offset = cdb_tag - head;

	// done stays set after retirement until the slot is reused,
	// which covers a lookup in the cycle the map entry is still live
	assign read_done_a = done[read_tag_a];
	assign read_done_b = done[read_tag_b];
	assign read_value_a = value_mem[read_tag_a];
	assign read_value_b = value_mem[read_tag_b];

	////////////////////
	// queue update
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
			if (retire) begin
				head <= head + TAG_W'(1);
			end
			if (cdb_valid) begin
				done[cdb_tag] <= 1'b1;
			end
			if (alloc_valid) begin
				done[tail] <= 1'b0;
				tail <= tail + TAG_W'(1);
			end
			count <= count + CNT_W'(alloc_valid) - CNT_W'(retire);
		end
		// payload
		commit_reg <= dest_mem[head];
		commit_value <= value_mem[head];
		commit_tag <= head;
		if (alloc_valid) begin
			dest_mem[tail] <= dest_reg;
		end
		if (cdb_valid) begin
			value_mem[cdb_tag] <= cdb_value;
		end
	end

	// the input credits must stop the sender before the queue fills
	rob_no_overflow: assert property (@(posedge clock) disable iff (reset)
		alloc_valid |-> count != CNT_W'(ROB_DEPTH));

	// every broadcast belongs to a live entry that has not finished yet
	rob_bus_target_live: assert property (@(posedge clock) disable iff (reset)
		cdb_valid |-> ({1'b0, cdb_offset} < count) && !done[cdb_tag]);

endmodule

`default_nettype wire

/* source/tomasulo_core.sv */
////////////////////
// top level of the out-of-order core
// decode with rename, one reservation station, the alu and the rob
// the sender may push a word only while it holds a credit
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core #(
	parameter int ROB_DEPTH = core_pkg::DEFAULT_ROB_DEPTH
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               inst_valid,
	input  core_pkg::inst_t    inst,
	output logic               credit_return,
	output logic               commit_valid,
	output core_pkg::reg_idx_t commit_reg,
	output core_pkg::data_t    commit_value
);

	localparam int TAG_W = $clog2(ROB_DEPTH);

	// decode to station and rob
	logic               alloc_valid;
	logic [TAG_W-1:0]   alloc_tag;
	core_pkg::reg_idx_t dest_reg;
	isa_pkg::alu_op_t   alu_op;
	core_pkg::data_t    src_value_a;
	core_pkg::data_t    src_value_b;
	logic               src_ready_a;
	logic               src_ready_b;
	logic [TAG_W-1:0]   src_tag_a;
	logic [TAG_W-1:0]   src_tag_b;

	// operand reads from the rob
	logic [TAG_W-1:0] read_tag_a;
	logic [TAG_W-1:0] read_tag_b;
	logic             read_done_a;
	logic             read_done_b;
	core_pkg::data_t  read_value_a;
	core_pkg::data_t  read_value_b;

	// issue and data bus
	logic             issue_valid;
	isa_pkg::alu_op_t issue_op;
	core_pkg::data_t  issue_a;
	core_pkg::data_t  issue_b;
	logic [TAG_W-1:0] issue_tag;
	logic             cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	core_pkg::data_t  cdb_value;

	logic [TAG_W-1:0] commit_tag;

	// every retirement frees one slot
	assign credit_return = commit_valid;

	instr_decode #(.ROB_DEPTH(ROB_DEPTH)) instr_decode0 (
		.clock       (clock),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.alloc_tag   (alloc_tag),
		.read_done_a (read_done_a),
		.read_done_b (read_done_b),
		.read_value_a(read_value_a),
		.read_value_b(read_value_b),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_value   (cdb_value),
		.commit_valid(commit_valid),
		.commit_reg  (commit_reg),
		.commit_value(commit_value),
		.commit_tag  (commit_tag),
		.alloc_valid (alloc_valid),
		.dest_reg    (dest_reg),
		.alu_op      (alu_op),
		.read_tag_a  (read_tag_a),
		.read_tag_b  (read_tag_b),
		.src_value_a (src_value_a),
		.src_value_b (src_value_b),
		.src_ready_a (src_ready_a),
		.src_ready_b (src_ready_b),
		.src_tag_a   (src_tag_a),
		.src_tag_b   (src_tag_b)
	);

	reservation_station #(.ROB_DEPTH(ROB_DEPTH)) reservation_station0 (
		.clock      (clock),
		.reset      (reset),
		.alloc_valid(alloc_valid),
		.alu_op     (alu_op),
		.alloc_tag  (alloc_tag),
		.src_value_a(src_value_a),
		.src_value_b(src_value_b),
		.src_ready_a(src_ready_a),
		.src_ready_b(src_ready_b),
		.src_tag_a  (src_tag_a),
		.src_tag_b  (src_tag_b),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_value  (cdb_value),
		.issue_valid(issue_valid),
		.issue_op   (issue_op),
		.issue_a    (issue_a),
		.issue_b    (issue_b),
		.issue_tag  (issue_tag)
	);

	alu_unit #(.ROB_DEPTH(ROB_DEPTH)) alu_unit0 (
		.clock      (clock),
		.reset      (reset),
		.issue_valid(issue_valid),
		.issue_op   (issue_op),
		.issue_a    (issue_a),
		.issue_b    (issue_b),
		.issue_tag  (issue_tag),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_value  (cdb_value)
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer0 (
		.clock       (clock),
		.reset       (reset),
		.alloc_valid (alloc_valid),
		.dest_reg    (dest_reg),
		.read_tag_a  (read_tag_a),
		.read_tag_b  (read_tag_b),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_value   (cdb_value),
		.alloc_tag   (alloc_tag),
		.read_done_a (read_done_a),
		.read_done_b (read_done_b),
		.read_value_a(read_value_a),
		.read_value_b(read_value_b),
		.commit_valid(commit_valid),
		.commit_reg  (commit_reg),
		.commit_value(commit_value),
		.commit_tag  (commit_tag)
	);

endmodule

`default_nettype wire

/* verification/core_tb.sv */
////////////////////
// testbench for the out-of-order core
// sends a random instruction stream under credit control, runs each
// word at once on an in-order model, and checks every retirement
// against the queue of expected results
////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam int ROB_DEPTH    = 8;
	localparam int NUM_INSTS    = 2000;
	localparam int STALL_LIMIT  = 200;
	localparam int DRAIN_LIMIT  = 500;
	localparam int QUIET_CYCLES = 20;

	logic               clock;
	logic               reset;
	logic               inst_valid;
	core_pkg::inst_t    inst;
	logic               credit_return;
	logic               commit_valid;
	core_pkg::reg_idx_t commit_reg;
	core_pkg::data_t    commit_value;

	// in-order model and expected retirements
	core_pkg::data_t    model_regs [32];
	core_pkg::reg_idx_t exp_reg [$];
	core_pkg::data_t    exp_value [$];

	int          credits;
	int          sent;
	int          commits;
	int          mismatch_count;
	int          error_count;
	logic        timed_out;
	logic [31:0] rng_state;

	tomasulo_core #(.ROB_DEPTH(ROB_DEPTH)) dut0 (
		.clock        (clock),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.credit_return(credit_return),
		.commit_valid (commit_valid),
		.commit_reg   (commit_reg),
		.commit_value (commit_value)
	);

	always #10 clock = ~clock;

	////////////////////
	// stimulus helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic core_pkg::inst_t encode_r(input logic [6:0] funct7,
		input logic [2:0] funct3, input core_pkg::reg_idx_t rd,
		input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2);
		return {funct7, rs2, rs1, funct3, rd, isa_pkg::OPCODE_OP};
	endfunction

	function automatic core_pkg::inst_t encode_i(input logic [11:0] imm,
		input logic [2:0] funct3, input core_pkg::reg_idx_t rd, input core_pkg::reg_idx_t rs1);
		return {imm, rs1, funct3, rd, isa_pkg::OPCODE_OP_IMM};
	endfunction

	// registers x0 to x7 only, so chains through renamed registers are common
	function automatic core_pkg::inst_t random_instruction();
		logic [31:0]        r;
		logic [31:0]        a;
		core_pkg::reg_idx_t rd;
		core_pkg::reg_idx_t rs1;
		core_pkg::reg_idx_t rs2;
		int                 opsel;
		core_pkg::inst_t    word;
		r = next_random();
		a = next_random();
		rd = {2'b00, a[2:0]};
		rs1 = {2'b00, a[5:3]};
		rs2 = {2'b00, a[8:6]};
		opsel = int'(a[12:9]) % 6;
		if (r[3:0] < 4'd2) begin
			// raw word, nearly always unsupported
			word = next_random();
		end else if (r[3:0] < 4'd9) begin
			case (opsel)
				0:       word = encode_r(7'b0, isa_pkg::FUNCT3_ADD_SUB, rd, rs1, rs2);
				1:       word = encode_r(isa_pkg::FUNCT7_SUB, isa_pkg::FUNCT3_ADD_SUB, rd, rs1, rs2);
				2:       word = encode_r(7'b0, isa_pkg::FUNCT3_AND, rd, rs1, rs2);
				3:       word = encode_r(7'b0, isa_pkg::FUNCT3_OR, rd, rs1, rs2);
				4:       word = encode_r(7'b0, isa_pkg::FUNCT3_XOR, rd, rs1, rs2);
				default: word = encode_r(7'b0, isa_pkg::FUNCT3_SLT, rd, rs1, rs2);
			endcase
		end else begin
			case (a[10:9])
				2'd0:    word = encode_i(a[31:20], isa_pkg::FUNCT3_ADD_SUB, rd, rs1);
				2'd1:    word = encode_i(a[31:20], isa_pkg::FUNCT3_AND, rd, rs1);
				2'd2:    word = encode_i(a[31:20], isa_pkg::FUNCT3_OR, rd, rs1);
				default: word = encode_i(a[31:20], isa_pkg::FUNCT3_XOR, rd, rs1);
			endcase
		end
		return word;
	endfunction

	////////////////////
	// in-order model
	////////////////////

	// runs one word on the model and queues its expected retirement
	task automatic execute_model(input core_pkg::inst_t w);
		logic [6:0]         opcode;
		logic [2:0]         f3;
		logic [6:0]         f7;
		core_pkg::reg_idx_t rd;
		core_pkg::data_t    a;
		core_pkg::data_t    b;
		core_pkg::data_t    imm;
		core_pkg::data_t    value;
		logic               known;
		opcode = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		rd = w[11:7];
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		known = 1'b1;
		value = '0;
		if (opcode == isa_pkg::OPCODE_OP && f7 == 7'b0) begin
			if (f3 == isa_pkg::FUNCT3_ADD_SUB) value = a + b;
			else if (f3 == isa_pkg::FUNCT3_SLT) value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			else if (f3 == isa_pkg::FUNCT3_XOR) value = a ^ b;
			else if (f3 == isa_pkg::FUNCT3_OR) value = a | b;
			else if (f3 == isa_pkg::FUNCT3_AND) value = a & b;
			else known = 1'b0;
		end else if (opcode == isa_pkg::OPCODE_OP && f7 == isa_pkg::FUNCT7_SUB &&
			f3 == isa_pkg::FUNCT3_ADD_SUB) begin
			value = a - b;
		end else if (opcode == isa_pkg::OPCODE_OP_IMM) begin
			if (f3 == isa_pkg::FUNCT3_ADD_SUB) value = a + imm;
			else if (f3 == isa_pkg::FUNCT3_XOR) value = a ^ imm;
			else if (f3 == isa_pkg::FUNCT3_OR) value = a | imm;
			else if (f3 == isa_pkg::FUNCT3_AND) value = a & imm;
			else known = 1'b0;
		end else begin
			known = 1'b0;
		end
		// anything else retires as addi x0, x0, 0
		if (!known) begin
			rd = '0;
			value = '0;
		end
		exp_reg.push_back(rd);
		exp_value.push_back(value);
		// x0 keeps reading as zero
		if (rd != '0) begin
			model_regs[rd] = value;
		end
	endtask

	// called once per cycle at the falling edge
	task automatic check_commit();
		core_pkg::reg_idx_t want_reg;
		core_pkg::data_t    want_value;
		if (commit_valid) begin
			if (exp_reg.size() == 0) begin
				error_count++;
				$display("Error at %0t: commit with no instruction outstanding", $time);
			end else begin
				want_reg = exp_reg.pop_front();
				want_value = exp_value.pop_front();
				commits++;
				if (commit_reg !== want_reg || commit_value !== want_value) begin
					mismatch_count++;
					$display("Mismatch at %0t: commit %0d expected x%0d = %h, got x%0d = %h",
						$time, commits, want_reg, want_value, commit_reg, commit_value);
				end
			end
		end
		if (credit_return) begin
			credits++;
		end
		if (credits > ROB_DEPTH || credits + exp_reg.size() != ROB_DEPTH) begin
			error_count++;
			$display("Error at %0t: %0d credits held with %0d instructions in flight",
				$time, credits, exp_reg.size());
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		core_pkg::inst_t word;
		int              stall_cycles;
		int              wait_cycles;
		clock = 1'b0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		rng_state = 32'd39410;
		credits = ROB_DEPTH;
		sent = 0;
		commits = 0;
		mismatch_count = 0;
		error_count = 0;
		timed_out = 1'b0;
		stall_cycles = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end

		for (int i = 0; i < 5; i++) begin
			@(posedge clock);
		end
		@(negedge clock);
		reset = 1'b0;

		// random stream, one credit spent per valid cycle
		while (sent < NUM_INSTS && !timed_out) begin
			@(negedge clock);
			check_commit();
			if (credits > 0 && (next_random() & 32'h3) != 32'h0) begin
				word = random_instruction();
				execute_model(word);
				inst_valid = 1'b1;
				inst = word;
				credits--;
				sent++;
				stall_cycles = 0;
			end else begin
				// garbage on inst while not valid
				inst_valid = 1'b0;
				inst = next_random();
				if (credits == 0) begin
					stall_cycles++;
				end
				if (stall_cycles > STALL_LIMIT) begin
					timed_out = 1'b1;
					$display("Timeout at %0t: no credit came back for %0d cycles",
						$time, STALL_LIMIT);
				end
			end
		end

		// drain until every instruction retired and all credits are home
		wait_cycles = 0;
		while (!timed_out && (exp_reg.size() != 0 || credits != ROB_DEPTH)) begin
			@(negedge clock);
			check_commit();
			inst_valid = 1'b0;
			wait_cycles++;
			if (wait_cycles > DRAIN_LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout at %0t: %0d instructions never retired", $time, exp_reg.size());
			end
		end

		// idle core must stay silent
		if (!timed_out) begin
			for (int i = 0; i < QUIET_CYCLES; i++) begin
				@(negedge clock);
				check_commit();
			end
			if (credits != ROB_DEPTH) begin
				error_count++;
				$display("Error at %0t: only %0d of %0d credits came back", $time, credits, ROB_DEPTH);
			end
		end

		$display("%0d sent, %0d retired, %0d mismatches, %0d other errors, %0d timeouts",
			sent, commits, mismatch_count, error_count, timed_out ? 1 : 0);
		if (mismatch_count == 0 && error_count == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
source/isa_pkg.sv
source/core_pkg.sv
source/instr_decode.sv
source/reservation_station.sv
source/alu_unit.sv
source/reorder_buffer.sv
source/tomasulo_core.sv
verification/core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = core_tb
RTL_TOP   = tomasulo_core
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
